// File: source/console_macros.svh
`ifndef CONSOLE_MACROS_SVH
`define CONSOLE_MACROS_SVH

// Screen geometry
`define CON_COLS   32
`define CON_ROWS   19
`define CON_CELLS  608

// ------------------------------
// Control codes in the text stream
`define CHR_AT     8'd22
`define CHR_HOME   8'd12
`define CHR_END    8'hFF
`define CHR_SPACE  8'h20

// ------------------------------
// String start addresses in message_rom
`define MSG_VGA    7'd0
`define MSG_NTSC   7'd8
`define MSG_PAL    7'd16
`define MSG_AT_ID  7'd24
`define MSG_AT_MEM 7'd28
`define MSG_AT_SD  7'd32
`define MSG_MOUSE  7'd36
`define MSG_OK     7'd43
`define MSG_ERROR  7'd49
`define MSG_WAIT   7'd55

`endif

// File: source/console_pkg.sv
package console_pkg;

   typedef logic [7:0]  char_t;       // One character code
   typedef logic [9:0]  cell_addr_t;  // Linear cell index, row * 32 + col
   typedef logic [4:0]  row_t;
   typedef logic [4:0]  col_t;
   typedef logic [6:0]  str_addr_t;   // Message ROM address
   typedef logic [56:0] chip_id_t;

   // Progress wins over result when both are set
   typedef struct packed {
      logic progress;
      logic result;
   } test_status_t;

   typedef struct packed {
      logic         vga;
      logic         mode;     // 0 PAL, 1 NTSC
      chip_id_t     chip_id;
      test_status_t memtest;
      test_status_t sdtest;
      logic [2:0]   mouse;    // Bit 0 left, bit 1 right, bit 2 middle
   } status_t;

   typedef enum logic [3:0] {
      R_HOME, R_VIDEO, R_ID, R_ID_DIGIT,
      R_MEM, R_MEM_RES, R_SD, R_SD_RES, R_MOUSE,
      R_STR, R_STR_CHECK, R_SEND, R_SEND_DONE
   } report_state_e;

   typedef enum logic [2:0] {
      IDLE, CMD, AT_ROW, AT_COL, CLEAR, PUT
   } writer_state_e;

endpackage

// File: source/message_rom.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module message_rom import console_pkg::*; (
   input  logic       clk,
   input  str_addr_t  rom_addr,
   input  logic [2:0] mouse,
   output char_t      rom_char
);

   localparam int ROM_LEN = 61;

   // All strings back to back, first byte at the top
   localparam logic [8*ROM_LEN-1:0] ROM_TEXT = {
      `CHR_AT, 8'd3,  8'd10, "VGA ",  `CHR_END,   // MSG_VGA
      `CHR_AT, 8'd3,  8'd10, "NTSC",  `CHR_END,   // MSG_NTSC
      `CHR_AT, 8'd3,  8'd10, "PAL ",  `CHR_END,   // MSG_PAL
      `CHR_AT, 8'd4,  8'd10,          `CHR_END,   // MSG_AT_ID
      `CHR_AT, 8'd6,  8'd21,          `CHR_END,   // MSG_AT_MEM
      `CHR_AT, 8'd12, 8'd21,          `CHR_END,   // MSG_AT_SD
      `CHR_AT, 8'd14, 8'd21, "   ",   `CHR_END,   // MSG_MOUSE, live buttons
      "OK   ",                        `CHR_END,
      "ERROR",                        `CHR_END,
      "wait ",                        `CHR_END
   };

   char_t table_char;

   always_comb begin
      if (rom_addr >= ROM_LEN)
         table_char = `CHR_END;
      else
         table_char = ROM_TEXT[8*(ROM_LEN-1-int'(rom_addr)) +: 8];
   end

   // ------------------------------
   // Registered read, buttons patched in on the fly
   always_ff @(posedge clk) begin
      if (rom_addr == `MSG_MOUSE + 7'd3)
         rom_char <= mouse[0] ? "L" : `CHR_SPACE;
      else if (rom_addr == `MSG_MOUSE + 7'd4)
         rom_char <= mouse[2] ? "M" : `CHR_SPACE;
      else if (rom_addr == `MSG_MOUSE + 7'd5)
         rom_char <= mouse[1] ? "R" : `CHR_SPACE;
      else
         rom_char <= table_char;
   end

endmodule

// File: source/id_digit_shifter.sv
`timescale 1ns/1ns

module id_digit_shifter import console_pkg::*; (
   input  logic     clk,
   input  logic     arst_n,
   input  chip_id_t chip_id,
   input  logic     id_load,
   input  logic     id_shift,
   output char_t    id_char,
   output logic     id_last
);

   logic [59:0] id_reg;     // 15 nibbles, top three bits zero
   logic [3:0]  digit_cnt;

   always_ff @(posedge clk) begin
      if (id_load)
         id_reg <= {3'b000, chip_id};
      else if (id_shift)
         id_reg <= {id_reg[55:0], 4'h0};
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         digit_cnt <= '0;
      else if (id_load)
         digit_cnt <= '0;
      else if (id_shift)
         digit_cnt <= digit_cnt + 4'd1;
   end

   // Upper-case hex of the top nibble
   assign id_char = (id_reg[59:56] < 4'd10) ? (8'h30 + {4'h0, id_reg[59:56]})
                                            : (8'h37 + {4'h0, id_reg[59:56]});
   assign id_last = (digit_cnt == 4'd15);

endmodule

// File: source/report_sequencer.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module report_sequencer import console_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  status_t   status,
   output str_addr_t rom_addr,
   input  char_t     rom_char,
   output logic      id_load,
   output logic      id_shift,
   input  char_t     id_char,
   input  logic      id_last,
   output logic      put,
   output char_t     put_char,
   input  logic      busy
);

   report_state_e state, ret_str, ret_send;

   function automatic str_addr_t result_msg(test_status_t t);
      if (t.progress)
         return `MSG_WAIT;
      else if (t.result)
         return `MSG_OK;
      else
         return `MSG_ERROR;
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= R_HOME;
         ret_str  <= R_VIDEO;
         ret_send <= R_VIDEO;
         rom_addr <= '0;
         put      <= 1'b0;
         put_char <= '0;
         id_load  <= 1'b0;
         id_shift <= 1'b0;
      end else begin
         id_load  <= 1'b0;  // Single-cycle pulses
         id_shift <= 1'b0;
         case (state)
            R_HOME: begin                     // Once after reset
               put_char <= `CHR_HOME;
               ret_send <= R_VIDEO;
               state    <= R_SEND;
            end
            R_VIDEO: begin
               if (status.vga)
                  rom_addr <= `MSG_VGA;
               else if (!status.mode)
                  rom_addr <= `MSG_PAL;
               else
                  rom_addr <= `MSG_NTSC;
               ret_str <= R_ID;
               state   <= R_STR;
            end
            R_ID: begin
               rom_addr <= `MSG_AT_ID;
               id_load  <= 1'b1;
               ret_str  <= R_ID_DIGIT;
               state    <= R_STR;
            end
            R_ID_DIGIT: begin
               if (id_last)
                  state <= R_MEM;
               else begin
                  put_char <= id_char;
                  id_shift <= 1'b1;             // Next nibble ready before return
                  ret_send <= R_ID_DIGIT;
                  state    <= R_SEND;
               end
            end
            R_MEM: begin
               rom_addr <= `MSG_AT_MEM;
               ret_str  <= R_MEM_RES;
               state    <= R_STR;
            end
            R_MEM_RES: begin
               rom_addr <= result_msg(status.memtest);
               ret_str  <= R_SD;
               state    <= R_STR;
            end
            R_SD: begin
               rom_addr <= `MSG_AT_SD;
               ret_str  <= R_SD_RES;
               state    <= R_STR;
            end
            R_SD_RES: begin
               rom_addr <= result_msg(status.sdtest);
               ret_str  <= R_MOUSE;
               state    <= R_STR;
            end
            R_MOUSE: begin
               rom_addr <= `MSG_MOUSE;
               ret_str  <= R_VIDEO;             // Loop forever
               state    <= R_STR;
            end

            // ------------------------------
            // String and character subroutines
            R_STR: begin                        // ROM latches current address
               rom_addr <= rom_addr + 7'd1;
               state    <= R_STR_CHECK;
            end
            R_STR_CHECK: begin
               if (rom_char == `CHR_END)
                  state <= ret_str;
               else begin
                  put_char <= rom_char;
                  ret_send <= R_STR;
                  state    <= R_SEND;
               end
            end
            R_SEND: begin
               if (!busy) begin
                  put   <= 1'b1;
                  state <= R_SEND_DONE;
               end
            end
            R_SEND_DONE: begin
               put   <= 1'b0;
               state <= ret_send;
            end
            default: state <= R_HOME;
         endcase
      end
   end

endmodule

// File: source/text_writer.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module text_writer import console_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       put,
   input  char_t      put_char,
   output logic       busy,
   output logic       wr_en,
   output cell_addr_t wr_addr,
   output char_t      wr_char
);

   writer_state_e state;
   cell_addr_t    cursor;
   row_t          row;
   char_t         cmd_char;   // Byte being decoded

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         cursor   <= '0;
         row      <= '0;
         busy     <= 1'b0;
         wr_en    <= 1'b0;
         wr_char  <= '0;
         cmd_char <= '0;
      end else begin
         case (state)
            IDLE, AT_ROW, AT_COL: begin
               if (put) begin
                  cmd_char <= put_char;
                  if (state == AT_ROW) begin
                     row   <= put_char[4:0];
                     state <= AT_COL;
                  end else if (state == AT_COL) begin
                     cursor <= {row, col_t'(put_char[4:0])};
                     state  <= IDLE;
                  end else if (put_char == `CHR_AT)
                     state <= AT_ROW;            // Arguments follow, stay free
                  else begin
                     busy  <= 1'b1;
                     state <= CMD;
                  end
               end
            end
            CMD: begin
               wr_en <= 1'b1;
               if (cmd_char == `CHR_HOME) begin
                  cursor  <= '0;
                  wr_char <= `CHR_SPACE;
                  state   <= CLEAR;
               end else begin
                  wr_char <= cmd_char;
                  state   <= PUT;
               end
            end
            CLEAR: begin                          // One cell per cycle
               if (cursor == cell_addr_t'(`CON_CELLS - 1)) begin
                  cursor <= '0;
                  wr_en  <= 1'b0;
                  busy   <= 1'b0;
                  state  <= IDLE;
               end else
                  cursor <= cursor + 10'd1;
            end
            PUT: begin
               wr_en  <= 1'b0;
               busy   <= 1'b0;
               cursor <= (cursor == cell_addr_t'(`CON_CELLS - 1)) ? '0 : cursor + 10'd1;
               state  <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign wr_addr = cursor;

endmodule

// File: source/screen_buffer.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module screen_buffer import console_pkg::*; (
   input  logic       clk,
   input  logic       wr_en,
   input  cell_addr_t wr_addr,
   input  char_t      wr_char,
   input  cell_addr_t fetch_addr,
   output char_t      fetch_char
);

   char_t mem [`CON_CELLS];   // 32 x 19 characters

   // Write port from the text writer
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_char;
   end

   // Fetch port, one cycle latency
   always_ff @(posedge clk) begin
      fetch_char <= mem[fetch_addr];
   end

endmodule

// File: source/status_console.sv
`timescale 1ns/1ns

module status_console import console_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  status_t    status,
   input  cell_addr_t fetch_addr,
   output char_t      fetch_char
);

   // ------------------------------
   // Sequencer side
   str_addr_t  rom_addr;
   char_t      rom_char;
   logic       id_load, id_shift, id_last;
   char_t      id_char;
   logic       put, busy;
   char_t      put_char;
   // Buffer write side
   logic       wr_en;
   cell_addr_t wr_addr;
   char_t      wr_char;

   report_sequencer u_seq (
      .clk, .arst_n, .status,
      .rom_addr, .rom_char,
      .id_load, .id_shift, .id_char, .id_last,
      .put, .put_char, .busy
   );

   message_rom u_rom (.clk, .rom_addr, .mouse(status.mouse), .rom_char);

   id_digit_shifter u_id (
      .clk, .arst_n, .chip_id(status.chip_id),
      .id_load, .id_shift, .id_char, .id_last
   );

   text_writer u_writer (.clk, .arst_n, .put, .put_char, .busy, .wr_en, .wr_addr, .wr_char);

   screen_buffer u_buf (.clk, .wr_en, .wr_addr, .wr_char, .fetch_addr, .fetch_char);

endmodule

// File: sim/status_console_properties.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module status_console_properties import console_pkg::*; (
   input logic          clk,
   input logic          arst_n,
   input logic          put,
   input char_t         put_char,
   input logic          busy,
   input logic          wr_en,
   input cell_addr_t    wr_addr,
   input writer_state_e state
);

   logic [9:0] home_left;   // Clear cycles still owed

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         home_left <= '0;
      else if (put && state == IDLE && put_char == `CHR_HOME)
         home_left <= 10'(`CON_CELLS);
      else if (home_left != '0)
         home_left <= home_left - 10'd1;
   end

   // ------------------------------
   put_when_free: assert property (@(posedge clk) disable iff (!arst_n) put |-> !busy)
      else $error("put arrived while the writer was busy");

   addr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> wr_addr < `CON_CELLS)
      else $error("write address %0d is outside the screen", wr_addr);

   home_keeps_busy: assert property (@(posedge clk) disable iff (!arst_n)
      home_left != '0 |-> busy)
      else $error("busy dropped before the screen clear finished");

endmodule

bind text_writer status_console_properties u_props (
   .clk, .arst_n, .put, .put_char, .busy, .wr_en, .wr_addr, .state
);

// File: sim/status_console_tb.sv
`timescale 1ns/1ns
`include "console_macros.svh"

module status_console_tb import console_pkg::*; ();

   localparam int SCENARIOS       = 32;
   localparam int RESET_SETTLE    = 2500;   // First pass including HOME
   localparam int SETTLE_CYCLES   = 3000;   // Two report passes
   localparam int WATCHDOG_CYCLES = SCENARIOS * 4000 + 3000;

   logic        clk;
   logic        arst_n;
   status_t     status;
   cell_addr_t  fetch_addr;
   char_t       fetch_char;
   logic [63:0] rng;
   logic        check_req;   // Raised by stimulus, cleared by compare
   string       scenario;

   status_console dut (.clk, .arst_n, .status, .fetch_addr, .fetch_char);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [63:0] xorshift64(logic [63:0] x);
      logic [63:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 7);
      y = y ^ (y << 17);
      return y;
   endfunction

   // ------------------------------
   // Reference screen
   function automatic char_t hex_ascii(logic [3:0] n);
      string digits;
      digits = "0123456789ABCDEF";
      return digits[n];
   endfunction

   function automatic string status_text(test_status_t t);
      if (t.progress)
         return "wait ";
      else if (t.result)
         return "OK   ";
      return "ERROR";
   endfunction

   function automatic char_t expected_cell(status_t s, cell_addr_t a);
      int          row;
      int          col;
      string       text;
      logic [59:0] id_full;
      char_t       c;
      row     = int'(a) / `CON_COLS;
      col     = int'(a) % `CON_COLS;
      id_full = {3'b000, s.chip_id};
      c       = `CHR_SPACE;
      if (row == 3 && col >= 10 && col < 14) begin
         if (s.vga)
            text = "VGA ";
         else if (s.mode)
            text = "NTSC";
         else
            text = "PAL ";
         c = text[col - 10];
      end else if (row == 4 && col >= 10 && col < 25)
         c = hex_ascii(id_full[4*(24 - col) +: 4]);   // Column 10 is the top nibble
      else if ((row == 6 || row == 12) && col >= 21 && col < 26) begin
         text = status_text(row == 6 ? s.memtest : s.sdtest);
         c    = text[col - 21];
      end else if (row == 14 && col == 21 && s.mouse[0])
         c = "L";
      else if (row == 14 && col == 22 && s.mouse[2])
         c = "M";
      else if (row == 14 && col == 23 && s.mouse[1])
         c = "R";
      return c;
   endfunction

   task automatic check_char(char_t got, char_t exp, cell_addr_t addr);
      if (got !== exp) begin
         $display("ERROR: fetch_char at cell %0d (row %0d col %0d), %s: got %h, expected %h",
                  addr, addr / `CON_COLS, addr % `CON_COLS, scenario, got, exp);
         $display("Simulation failed");
         $fatal(1, "Screen content mismatch");
      end
   endtask

   task automatic apply_status(status_t s);
      @(posedge clk);
      #1;
      status = s;
   endtask

   task automatic check_screen_after(int cycles, string name);
      repeat (cycles) @(posedge clk);
      scenario  = name;
      check_req = 1'b1;
      wait (check_req == 1'b0);
   endtask

   // ------------------------------
   // Compare process, one fetched cell per cycle
   initial begin
      forever begin
         wait (check_req == 1'b1);
         @(posedge clk);
         #1;
         for (int a = 0; a < `CON_CELLS; a++) begin
            fetch_addr = cell_addr_t'(a);
            @(posedge clk);
            #1;
            check_char(fetch_char, expected_cell(status, cell_addr_t'(a)), cell_addr_t'(a));
         end
         check_req = 1'b0;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the screen checks did not finish in %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Watchdog expired");
   end

   // ------------------------------
   // Stimulus
   initial begin
      status_t s;
      arst_n     = 1'b0;
      fetch_addr = '0;
      check_req  = 1'b0;
      scenario   = "reset";
      rng        = xorshift64(64'd63);
      s          = '0;
      s.vga      = 1'b1;
      s.chip_id  = rng[56:0];
      status     = s;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      check_screen_after(RESET_SETTLE, "after reset");

      for (int m = 0; m < 3; m++) begin          // VGA, PAL, NTSC
         s.vga  = (m == 0);
         s.mode = (m == 2);
         apply_status(s);
         check_screen_after(SETTLE_CYCLES, "video mode label");
      end

      for (int i = 0; i < 4; i++) begin
         rng       = xorshift64(rng);
         s.chip_id = rng[56:0];
         apply_status(s);
         check_screen_after(SETTLE_CYCLES, "chip ID");
      end

      for (int m = 0; m < 4; m++) begin
         for (int d = 0; d < 4; d++) begin
            s.memtest = test_status_t'(2'(m));
            s.sdtest  = test_status_t'(2'(d));
            apply_status(s);
            check_screen_after(SETTLE_CYCLES, "memory and SD test status");
         end
      end

      for (int b = 0; b < 8; b++) begin
         s.mouse = 3'(b);
         apply_status(s);
         check_screen_after(SETTLE_CYCLES, "mouse buttons");
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: src.f
+incdir+source
source/console_pkg.sv
source/message_rom.sv
source/id_digit_shifter.sv
source/report_sequencer.sv
source/text_writer.sv
source/screen_buffer.sv
source/status_console.sv
sim/status_console_properties.sv
sim/status_console_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the status console simulation with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module status_console_tb -Mdir obj_dir -o status_console_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/status_console_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulator exited with status $run_status"
   exit 1
fi
exit 0
